// File: design/video_pkg.sv
`default_nettype none

package video_pkg;

	// Playfield held in the frame buffer
	localparam int SCREEN_W = 320;
	localparam int SCREEN_H = 240;

	typedef logic [8:0]  coord_t;  // Pixel coordinate
	typedef logic [11:0] colour_t; // 4 bits each of r, g, b

	// 640x480 horizontal timing in pixel clocks
	localparam int H_VISIBLE = 640;
	localparam int H_FRONT   = 16;
	localparam int H_SYNC    = 96;
	localparam int H_BACK    = 48;
	localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK; // 800

	// Vertical timing in lines
	localparam int V_VISIBLE = 480;
	localparam int V_FRONT   = 10;
	localparam int V_SYNC    = 2;
	localparam int V_BACK    = 33;
	localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK; // 525

	localparam int H_CNT_W = $clog2(H_TOTAL);
	localparam int V_CNT_W = $clog2(V_TOTAL);
	localparam int ADDR_W  = 17; // Covers 76800 entries

endpackage

`default_nettype wire

// File: design/game_pkg.sv
`default_nettype none

package game_pkg;

	typedef enum logic [2:0] {
		IDLE,  // Waiting for go
		SLIDE, // Sweeping along the top
		DROP,  // Going down
		HAUL,  // Coming back up
		OVER   // Game stopped
	} hook_state_t;

	typedef logic [4:0] col_t;   // Hook column 0..31
	typedef logic [4:0] len_t;   // Hook length 0..31
	typedef logic [7:0] score_t;

	localparam int CELL = 10; // Pixels per column or length unit

	// Step dividers in clocks
	localparam int SLIDE_DIV = 64;
	localparam int DROP_DIV  = 32;
	localparam int HAUL_DIV  = 128; // Slow with the nugget on
	localparam int DIV_W     = $clog2(HAUL_DIV);

	localparam score_t GOLD_VALUE = 8'd5;

	localparam video_pkg::colour_t COL_HOOK = 12'hf00; // Red
	localparam video_pkg::colour_t COL_GOLD = 12'hff0; // Yellow
	localparam video_pkg::colour_t COL_BG   = 12'h000; // Black

endpackage

`default_nettype wire

// File: design/pixel_wr_if.sv
`timescale 1ns/10ps
`default_nettype none

interface pixel_wr_if;
	import video_pkg::*;

	coord_t  x;      // Playfield column
	coord_t  y;      // Playfield row
	colour_t colour;
	logic    plot;   // Write strobe, one pixel per clock

	// Renderer side
	modport source (output x, output y, output colour, output plot);
	// Frame buffer side
	modport sink (input x, input y, input colour, input plot);

endinterface

`default_nettype wire

// File: design/hook_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module hook_ctrl (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  go,
	input  logic                  drop,
	input  logic                  stop,
	input  game_pkg::col_t        gold_col,
	input  game_pkg::len_t        gold_row,
	output game_pkg::col_t        hook_col,
	output game_pkg::len_t        hook_len,
	output game_pkg::hook_state_t state,
	output logic                  gold_taken,
	output game_pkg::score_t      score
);
	import game_pkg::*;

	logic [DIV_W-1:0] div;      // Shared step divider
	logic [DIV_W-1:0] div_last; // Terminal count for current state
	logic             step;     // Move the hook this clock
	logic             slide_up; // Sweeping rightwards
	len_t             len_up;
	len_t             len_dn;

	// Step period follows the state and the load
	always_comb begin
		case (state)
			SLIDE:   div_last = DIV_W'(SLIDE_DIV - 1);
			HAUL:    div_last = gold_taken ? DIV_W'(HAUL_DIV - 1) : DIV_W'(DROP_DIV - 1);
			default: div_last = DIV_W'(DROP_DIV - 1);
		endcase
	end

	assign step   = (div == div_last);
	assign len_up = hook_len + 1'b1;
	assign len_dn = hook_len - 1'b1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= IDLE;
			div        <= '0;
			hook_col   <= '0;
			hook_len   <= '0;
			slide_up   <= 1'b1;
			gold_taken <= 1'b0;
			score      <= '0;
		end else if (stop) begin
			state <= OVER; // Wins over everything
			div   <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (go) begin
						state <= SLIDE;
						div   <= '0; // Count from the go clock
					end
				end
				SLIDE: begin
					if (drop) begin
						state <= DROP; // Column frozen here
						div   <= '0;
					end else if (step) begin
						div <= '0;
						if (slide_up && hook_col == '1) begin
							slide_up <= 1'b0; // Bounce at right edge
							hook_col <= hook_col - 1'b1;
						end else if (!slide_up && hook_col == '0) begin
							slide_up <= 1'b1; // Bounce at left edge
							hook_col <= hook_col + 1'b1;
						end else begin
							hook_col <= slide_up ? hook_col + 1'b1 : hook_col - 1'b1;
						end
					end else begin
						div <= div + 1'b1;
					end
				end
				DROP: begin
					if (step) begin
						div      <= '0;
						hook_len <= len_up;
						if (hook_col == gold_col && len_up == gold_row) begin
							gold_taken <= 1'b1; // Catch
							state      <= HAUL;
						end else if (len_up == '1) begin
							state <= HAUL; // Bottom reached, empty
						end
					end else begin
						div <= div + 1'b1;
					end
				end
				HAUL: begin
					if (step) begin
						div      <= '0;
						hook_len <= len_dn;
						if (len_dn == '0) begin
							state      <= SLIDE; // Back on top
							gold_taken <= 1'b0;
							if (gold_taken)
								score <= score + GOLD_VALUE;
						end
					end else begin
						div <= div + 1'b1;
					end
				end
				OVER:    state <= OVER; // Held until reset
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/view.sv
`timescale 1ns/10ps
`default_nettype none

module view (
	input  logic              clk,
	input  logic              rst_n,
	input  game_pkg::col_t    hook_col,
	input  game_pkg::len_t    hook_len,
	input  game_pkg::col_t    gold_col,
	input  game_pkg::len_t    gold_row,
	input  logic              gold_taken,
	pixel_wr_if.source        pix
);
	import video_pkg::*;
	import game_pkg::*;

	coord_t  scan_x;  // Raster position
	coord_t  scan_y;
	coord_t  hook_x;  // Hook line column
	coord_t  tip_y;   // Lowest hook row
	coord_t  blk_x;   // Nugget block corner
	coord_t  blk_y;
	logic    on_hook;
	logic    on_gold;
	colour_t colour;

	assign hook_x = coord_t'(hook_col * CELL);
	assign tip_y  = coord_t'(hook_len * CELL);

	// Nugget rides on the hook tip once taken
	assign blk_x = gold_taken ? hook_x : coord_t'(gold_col * CELL);
	assign blk_y = gold_taken ? tip_y : coord_t'(gold_row * CELL);

	assign on_hook = (scan_x == hook_x) && (scan_y <= tip_y);
	assign on_gold = (scan_x >= blk_x) && (scan_x < blk_x + CELL) &&
	                 (scan_y >= blk_y) && (scan_y < blk_y + CELL);

	always_comb begin
		if (on_gold)
			colour = COL_GOLD; // Nugget drawn over the line
		else if (on_hook)
			colour = COL_HOOK;
		else
			colour = COL_BG;
	end

	// Raster scan, never pauses
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_x   <= '0;
			scan_y   <= '0;
			pix.plot <= 1'b0;
		end else begin
			pix.plot <= 1'b1; // Write every clock
			if (scan_x == coord_t'(SCREEN_W - 1)) begin
				scan_x <= '0;
				if (scan_y == coord_t'(SCREEN_H - 1))
					scan_y <= '0; // Frame done
				else
					scan_y <= scan_y + 1'b1;
			end else begin
				scan_x <= scan_x + 1'b1;
			end
		end
	end

	// Pixel payload, follows the counters by one clock
	always_ff @(posedge clk) begin
		pix.x      <= scan_x;
		pix.y      <= scan_y;
		pix.colour <= colour;
	end

endmodule

`default_nettype wire

// File: design/vga_adapter.sv
`timescale 1ns/10ps
`default_nettype none

module vga_adapter (
	input  logic       clk,
	input  logic       rst_n,
	pixel_wr_if.sink   pix,
	output logic       vga_clk,
	output logic       vga_hs,
	output logic       vga_vs,
	output logic       vga_blank_n,
	output logic       vga_sync_n,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b
);
	import video_pkg::*;

	colour_t             fb [SCREEN_W * SCREEN_H]; // Frame buffer
	logic [ADDR_W-1:0]   wr_addr;
	logic [ADDR_W-1:0]   rd_addr;
	colour_t             rd_data;
	logic                pix_en;  // Half-rate pixel enable
	logic [H_CNT_W-1:0]  h_cnt;
	logic [V_CNT_W-1:0]  v_cnt;
	logic                visible;
	logic                hs_raw;
	logic                vs_raw;
	logic                vis_d1;  // First pipeline stage
	logic                hs_d1;
	logic                vs_d1;

	assign wr_addr = ADDR_W'(pix.y * SCREEN_W + pix.x);

	always_ff @(posedge clk) begin
		if (pix.plot)
			fb[wr_addr] <= pix.colour;
	end

	// Each playfield pixel covers 2x2 screen pixels
	assign visible = (h_cnt < H_CNT_W'(H_VISIBLE)) && (v_cnt < V_CNT_W'(V_VISIBLE));
	assign rd_addr = visible ? ADDR_W'((v_cnt >> 1) * SCREEN_W + (h_cnt >> 1)) : '0;

	always_ff @(posedge clk) begin
		rd_data <= fb[rd_addr];
	end

	// Active-low sync windows
	assign hs_raw = !((h_cnt >= H_CNT_W'(H_VISIBLE + H_FRONT)) &&
	                  (h_cnt <  H_CNT_W'(H_VISIBLE + H_FRONT + H_SYNC)));
	assign vs_raw = !((v_cnt >= V_CNT_W'(V_VISIBLE + V_FRONT)) &&
	                  (v_cnt <  V_CNT_W'(V_VISIBLE + V_FRONT + V_SYNC)));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pix_en <= 1'b0;
			h_cnt  <= '0;
			v_cnt  <= '0;
		end else begin
			pix_en <= ~pix_en;
			if (pix_en) begin
				if (h_cnt == H_CNT_W'(H_TOTAL - 1)) begin
					h_cnt <= '0; // End of line
					if (v_cnt == V_CNT_W'(V_TOTAL - 1))
						v_cnt <= '0;
					else
						v_cnt <= v_cnt + 1'b1;
				end else begin
					h_cnt <= h_cnt + 1'b1;
				end
			end
		end
	end

	// Two-stage output, lines up syncs with buffer read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vis_d1      <= 1'b0;
			hs_d1       <= 1'b1;
			vs_d1       <= 1'b1;
			vga_blank_n <= 1'b0;
			vga_hs      <= 1'b1;
			vga_vs      <= 1'b1;
			vga_r       <= '0;
			vga_g       <= '0;
			vga_b       <= '0;
		end else begin
			vis_d1      <= visible;
			hs_d1       <= hs_raw;
			vs_d1       <= vs_raw;
			vga_blank_n <= vis_d1;
			vga_hs      <= hs_d1;
			vga_vs      <= vs_d1;
			vga_r       <= vis_d1 ? {2{rd_data[11:8]}} : 8'h00; // Nibble repeated
			vga_g       <= vis_d1 ? {2{rd_data[7:4]}} : 8'h00;
			vga_b       <= vis_d1 ? {2{rd_data[3:0]}} : 8'h00;
		end
	end

	assign vga_clk    = pix_en;
	assign vga_sync_n = 1'b1; // Sync-on-green unused

endmodule

`default_nettype wire

// File: design/gold_miner.sv
`timescale 1ns/10ps
`default_nettype none

module gold_miner (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [3:1] key,
	input  logic [9:0] sw,
	output logic [9:0] ledr,
	output logic       vga_clk,
	output logic       vga_hs,
	output logic       vga_vs,
	output logic       vga_blank_n,
	output logic       vga_sync_n,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b
);
	import game_pkg::*;

	logic        go;         // Keys are active low on the board
	logic        drop;
	logic        stop;
	col_t        gold_col;
	len_t        gold_row;
	col_t        hook_col;
	len_t        hook_len;
	hook_state_t state;
	logic        gold_taken;
	score_t      score;

	assign go       = ~key[3];
	assign drop     = ~key[2];
	assign stop     = ~key[1];
	assign gold_col = sw[4:0];
	assign gold_row = sw[9:5];

	assign ledr = {state == OVER, 1'b0, score}; // Game over lamp on top

	pixel_wr_if pix_bus ();

	hook_ctrl u_hook (
		.clk(clk), .rst_n(rst_n), .go(go), .drop(drop), .stop(stop),
		.gold_col(gold_col), .gold_row(gold_row), .hook_col(hook_col),
		.hook_len(hook_len), .state(state), .gold_taken(gold_taken), .score(score)
	);

	view u_view (
		.clk(clk), .rst_n(rst_n), .hook_col(hook_col), .hook_len(hook_len),
		.gold_col(gold_col), .gold_row(gold_row), .gold_taken(gold_taken),
		.pix(pix_bus.source)
	);

	vga_adapter u_vga (
		.clk(clk), .rst_n(rst_n), .pix(pix_bus.sink), .vga_clk(vga_clk),
		.vga_hs(vga_hs), .vga_vs(vga_vs), .vga_blank_n(vga_blank_n),
		.vga_sync_n(vga_sync_n), .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b)
	);

endmodule

`default_nettype wire

// File: verif/gold_miner_tb.sv
`timescale 1ns/10ps
`default_nettype none

module gold_miner_tb;

	localparam int CLK_NS      = 8;
	localparam int LINE_CLKS   = 1600;   // 800 pixel clocks at half rate
	localparam int HS_LOW_CLKS = 192;
	localparam int FRAME_CLKS  = 840000; // 525 lines
	localparam int VS_LOW_CLKS = 3200;
	localparam int ACTIVE_CLKS = 1280;
	localparam int HS_TO_LINE  = 288;    // hs fall to pixel 0 of next line
	localparam int VS_TO_ROW0  = 35;     // hs falls after vs fall up to the line before row 0
	localparam int SLIDE_CLKS  = 64;
	localparam int DROP_CLKS   = 32;
	localparam int HAUL_CLKS   = 128;
	localparam int TRIAL_CLKS  = 62 * SLIDE_CLKS + (DROP_CLKS + HAUL_CLKS) * 31 + 16;
	localparam int WATCHDOG_NS = (3 * FRAME_CLKS + 8 * TRIAL_CLKS) * CLK_NS;
	localparam int CAT_RESET   = 0;
	localparam int CAT_SYNC    = 1;
	localparam int CAT_GAME    = 2;
	localparam int CAT_PICTURE = 3;

	logic        clk;
	logic        rst_n;
	logic [3:1]  key;
	logic [9:0]  sw;
	logic [9:0]  ledr;
	logic        vga_clk;
	logic        vga_hs;
	logic        vga_vs;
	logic        vga_blank_n;
	logic        vga_sync_n;
	logic [7:0]  vga_r;
	logic [7:0]  vga_g;
	logic [7:0]  vga_b;

	int          errs [4] = '{0, 0, 0, 0}; // Per check group
	logic [31:0] lfsr;
	bit          mon_on;                   // Sync monitor armed
	int          slide_col;                // Expected hook column
	bit          slide_up;
	int          slide_div;
	int          exp_score;
	logic [23:0] line_rgb [640];           // One captured screen line

	// Sync monitor state
	logic        hs_q;
	logic        vs_q;
	logic        blank_q;
	logic        clk_q;                    // Last vga_clk level
	bit          clk_seen;
	bit          hs_seen;
	bit          vs_seen;
	int          hs_cnt;
	int          vs_cnt;
	int          hs_low;
	int          vs_low;
	int          blank_run;
	int          hs_periods;
	int          vs_periods;
	int          blank_lines;

	gold_miner uut (
		.clk(clk), .rst_n(rst_n), .key(key), .sw(sw), .ledr(ledr),
		.vga_clk(vga_clk), .vga_hs(vga_hs), .vga_vs(vga_vs),
		.vga_blank_n(vga_blank_n), .vga_sync_n(vga_sync_n),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	task automatic expect_eq(input string name, input logic [31:0] got,
			input logic [31:0] exp, input int cat);
		assert (got === exp) else begin
			$display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
			errs[cat] = errs[cat] + 1;
		end
	endtask

	task automatic print_counts();
		$display("Errors: reset %0d, sync %0d, game %0d, picture %0d",
			errs[CAT_RESET], errs[CAT_SYNC], errs[CAT_GAME], errs[CAT_PICTURE]);
	endtask

	// Galois LFSR with taps 32 30 26 25
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		int i;
		v = 0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr); // One step per bit
			v    = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	task automatic check_idle_outputs();
		expect_eq("ledr", ledr, 0, CAT_RESET);
		expect_eq("vga_hs", vga_hs, 1, CAT_RESET);
		expect_eq("vga_vs", vga_vs, 1, CAT_RESET);
	endtask

	task automatic apply_reset();
		@(negedge clk);
		rst_n = 1'b0;
		repeat (3) begin
			@(negedge clk);
			check_idle_outputs(); // During reset
		end
		rst_n = 1'b1;
		@(negedge clk);
		check_idle_outputs();     // First clock after
		exp_score = 0;
	endtask

	task automatic press_go();
		key[3] = 1'b0;
		@(negedge clk);
		key[3]    = 1'b1;
		slide_col = 0;          // Hook enters SLIDE at column 0
		slide_up  = 1'b1;
		slide_div = 0;
	endtask

	// Sweep model for one clock with a bounce at 0 and 31
	task automatic slide_tick();
		if (slide_div != SLIDE_CLKS - 1) begin
			slide_div++;
		end else begin
			slide_div = 0;
			if (slide_col == 31)
				slide_up = 1'b0;
			else if (slide_col == 0)
				slide_up = 1'b1;
			slide_col = slide_up ? slide_col + 1 : slide_col - 1;
		end
	endtask

	task automatic slide_until(input int col);
		while (slide_col != col) begin
			@(posedge clk);
			slide_tick();
			@(negedge clk);
		end
	endtask

	task automatic pulse_drop();
		key[2] = 1'b0;
		@(negedge clk);
		key[2] = 1'b1;
	endtask

	task automatic catch_trial(input int col, input int row);
		sw = 10'(row * 32 + col);
		slide_until(col);
		pulse_drop();
		repeat ((DROP_CLKS + HAUL_CLKS) * row - 1) @(negedge clk);
		expect_eq("ledr[7:0] before return", ledr[7:0], exp_score, CAT_GAME);
		@(negedge clk);
		exp_score = (exp_score + 5) % 256;
		expect_eq("ledr[7:0] after catch", ledr[7:0], exp_score, CAT_GAME);
		slide_div = 0; // Sweep restarts on the return clock
	endtask

	task automatic miss_trial(input int col, input int row);
		sw = 10'(row * 32 + col);
		slide_until(col ^ 16); // Any other column
		pulse_drop();
		repeat (2 * 31 * DROP_CLKS) @(negedge clk); // Down to 31 and back empty
		expect_eq("ledr[7:0] after miss", ledr[7:0], exp_score, CAT_GAME);
		slide_div = 0;
	endtask

	task automatic stop_trial();
		key[1] = 1'b0;
		@(negedge clk);
		key[1] = 1'b1;
		expect_eq("ledr[9]", ledr[9], 1, CAT_GAME);
		repeat (3) begin
			pulse_drop(); // Ignored in OVER
			repeat (2 * 31 * DROP_CLKS) @(negedge clk);
			expect_eq("ledr[7:0] after stop", ledr[7:0], exp_score, CAT_GAME);
			expect_eq("ledr[9]", ledr[9], 1, CAT_GAME);
		end
	endtask

	// Grabs screen row y of the next frame
	// Syncs and RGB share the two-clock output delay
	task automatic capture_line(input int y);
		int   falls;
		int   x;
		logic prev;
		prev = vga_vs;
		@(negedge clk);
		while (!(prev && !vga_vs)) begin
			prev = vga_vs;
			@(negedge clk);
		end
		falls = 0;
		prev  = vga_hs;
		while (falls < y + VS_TO_ROW0) begin
			@(negedge clk);
			if (prev && !vga_hs)
				falls++;
			prev = vga_hs;
		end
		repeat (HS_TO_LINE) @(negedge clk);
		expect_eq("vga_blank_n at line start", vga_blank_n, 1, CAT_PICTURE);
		for (x = 0; x < 640; x++) begin
			line_rgb[x] = {vga_r, vga_g, vga_b};
			repeat (2) @(negedge clk); // Each playfield pixel twice
		end
	endtask

	task automatic picture_check(input int col, input int row);
		int gx;
		int gy;
		int bx;
		gx = 2 * (col * 10 + 5);                   // Gold block centre on screen
		gy = 2 * (row * 10 + 5);
		bx = 2 * (((col + 16) % 32) * 10 + 5);     // Same line, far from gold and hook
		capture_line(gy);
		expect_eq("rgb at gold centre", line_rgb[gx], 24'hffff00, CAT_PICTURE);
		expect_eq("rgb on background", line_rgb[bx], 24'h000000, CAT_PICTURE);
	endtask

	// Sync monitor on the registered outputs
	always @(posedge clk) begin
		if (!rst_n || !mon_on) begin
			hs_q      = 1'b1;
			vs_q      = 1'b1;
			blank_q   = 1'b0;
			clk_seen  = 1'b0;
			hs_seen   = 1'b0;
			vs_seen   = 1'b0;
			hs_cnt    = 0;
			vs_cnt    = 0;
			hs_low    = 0;
			vs_low    = 0;
			blank_run = 0;
		end else begin
			hs_cnt++;
			vs_cnt++;
			if (clk_seen)
				expect_eq("vga_clk", vga_clk, !clk_q, CAT_SYNC); // Toggles every clock
			expect_eq("vga_sync_n", vga_sync_n, 1, CAT_SYNC);
			if (!vga_hs)
				hs_low++;
			if (!vga_vs)
				vs_low++;
			if (vga_blank_n)
				blank_run++;
			if (hs_q && !vga_hs) begin
				if (hs_seen) begin
					expect_eq("vga_hs period", hs_cnt, LINE_CLKS, CAT_SYNC);
					hs_periods++;
				end
				hs_seen = 1'b1;
				hs_cnt  = 0;
			end
			if (!hs_q && vga_hs) begin
				expect_eq("vga_hs low pulse", hs_low, HS_LOW_CLKS, CAT_SYNC);
				hs_low = 0;
			end
			if (vs_q && !vga_vs) begin
				if (vs_seen) begin
					expect_eq("vga_vs period", vs_cnt, FRAME_CLKS, CAT_SYNC);
					vs_periods++;
				end
				vs_seen = 1'b1;
				vs_cnt  = 0;
			end
			if (!vs_q && vga_vs) begin
				expect_eq("vga_vs low pulse", vs_low, VS_LOW_CLKS, CAT_SYNC);
				vs_low = 0;
			end
			if (blank_q && !vga_blank_n) begin
				expect_eq("vga_blank_n high run", blank_run, ACTIVE_CLKS, CAT_SYNC);
				blank_lines++;
				blank_run = 0;
			end
			if (!vga_blank_n)
				expect_eq("rgb in blanking", {vga_r, vga_g, vga_b}, 0, CAT_SYNC);
			hs_q     = vga_hs;
			vs_q     = vga_vs;
			blank_q  = vga_blank_n;
			clk_q    = vga_clk;
			clk_seen = 1'b1;
		end
	end

	initial begin
		int col;
		int row;
		key         = 3'b111; // All keys released
		sw          = '0;
		rst_n       = 1'b1;
		lfsr        = 32'h1d01;
		mon_on      = 1'b0;
		hs_periods  = 0;
		vs_periods  = 0;
		blank_lines = 0;
		apply_reset();
		mon_on = 1'b1;
		press_go();
		repeat (3) begin
			col = rand_bits(5);
			row = rand_bits(5) % 30 + 1;
			catch_trial(col, row);
		end
		col = rand_bits(5);
		row = rand_bits(5) % 30 + 1;
		miss_trial(col, row);
		col = rand_bits(5);
		row = rand_bits(5) % 30 + 1;
		catch_trial(col, row); // Also proves the return timing of the miss
		stop_trial();
		col = rand_bits(5) % 31 + 1;
		row = rand_bits(5) % 23 + 1;  // Block stays inside 240 rows
		sw  = 10'(row * 32 + col);
		apply_reset();                // Back to IDLE, score cleared
		picture_check(col, row);
		wait (vs_periods > 0);
		if (hs_periods == 0 || blank_lines == 0) begin
			$display("Sync monitor never saw a complete line");
			errs[CAT_SYNC] = errs[CAT_SYNC] + 1;
		end
		print_counts();
		if (errs[CAT_RESET] + errs[CAT_SYNC] + errs[CAT_GAME] + errs[CAT_PICTURE] == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		print_counts();
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
design/video_pkg.sv
design/game_pkg.sv
design/pixel_wr_if.sv
design/hook_ctrl.sv
design/view.sv
design/vga_adapter.sv
design/gold_miner.sv
verif/gold_miner_tb.sv

// File: Bender.yml
package:
  name: gold_miner

sources:
  - design/video_pkg.sv
  - design/game_pkg.sv
  - design/pixel_wr_if.sv
  - design/hook_ctrl.sv
  - design/view.sv
  - design/vga_adapter.sv
  - design/gold_miner.sv
  - target: test
    files:
      - verif/gold_miner_tb.sv
